// ==== files.f ====
hdl/fram_pkg.sv
hdl/frame_ram.sv
hdl/desc_fifo.sv
hdl/frame_writer.sv
hdl/frame_reader.sv
hdl/frame_buffer.sv
testbench/frame_buffer_props.sv
testbench/frame_buffer_check.sv
testbench/frame_buffer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the frame buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module frame_buffer_tb \
    -f files.f -o frame_buffer_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/frame_buffer_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log"
exit 1

// ==== testbench/frame_buffer_tb.sv ====
`timescale 1ns/1ps

module frame_buffer_tb;

    localparam int OUT_LOW  = 0;
    localparam int OUT_HIGH = 1;
    localparam int OUT_RAND = 2;

    logic                clk = 1'b0;
    logic                rst;
    fram_pkg::in_beat_t  in_beat;
    logic                in_valid;
    logic                in_ready;
    fram_pkg::out_beat_t out_beat;
    logic                out_valid;
    logic                out_ready = 1'b0;

    logic [31:0]         seed = 32'hb3263912;
    logic [31:0]         ready_seed = 32'hb3263912;
    int                  out_mode = OUT_LOW;
    int                  len_q[$];        // frame lengths, drawn before the run
    logic                good_q[$];
    fram_pkg::data_t     frame_data[64];
    fram_pkg::keep_t     frame_keep[64];
    int                  total_beats = 0;
    int                  watchdog_cycles = 0;
    int                  tb_errors = 0;
    int                  test_errors;
    logic                stall_seen;

    frame_buffer frame_buffer_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_in        (in_beat),
        .i_in_valid  (in_valid),
        .o_in_ready  (in_ready),
        .o_out       (out_beat),
        .o_out_valid (out_valid),
        .i_out_ready (out_ready)
    );

    frame_buffer_check check_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_out       (out_beat),
        .i_out_valid (out_valid),
        .i_out_ready (out_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        #1;
        ready_seed = lcg(ready_seed);
        if (out_mode == OUT_RAND)
            out_ready = (ready_seed[31:30] != 2'b00);  // about three cycles in four
        else
            out_ready = (out_mode == OUT_HIGH);
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int error_total();
        return check_i.errors + tb_errors;
    endfunction

    // expected output of one frame, a bad frame leaves nothing behind
    function automatic void expect_frame(input int len, input logic good);
        fram_pkg::out_beat_t b;
        if (good) begin
            for (int i = 0; i < len; i++) begin
                b.data = frame_data[i];
                b.keep = frame_keep[i];
                b.last = (i == len - 1);
                b.user = fram_pkg::len_t'(len);
                check_i.expect_beat(b);
            end
        end
    endfunction

    task automatic plan_frames(input int n, input int bad_mode);
        for (int f = 0; f < n; f++) begin
            seed = lcg(seed);
            len_q.push_back(1 + int'(seed[21:16]));  // 1 to 64 beats
            total_beats += 1 + int'(seed[21:16]);
            case (bad_mode)
                0:       good_q.push_back(1'b1);
                1:       good_q.push_back(f % 2 == 0);  // every other frame bad
                default: good_q.push_back(seed[31:30] != 2'b00);
            endcase
        end
    endtask

    // ready is looked at mid-cycle, where it is stable
    task automatic send_beat(input fram_pkg::in_beat_t b, input int gap);
        logic taken;
        taken = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        in_beat  = b;
        in_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frames(input int n, input logic gaps);
        int                 len;
        logic               good;
        fram_pkg::in_beat_t b;
        repeat (n) begin
            len  = len_q.pop_front();
            good = good_q.pop_front();
            for (int i = 0; i < len; i++) begin
                seed = lcg(seed);
                frame_data[i] = seed;
                frame_keep[i] = (i == len - 1) ? seed[27:24] : 4'hf;
            end
            expect_frame(len, good);
            for (int i = 0; i < len; i++) begin
                seed = lcg(seed);
                b.data = frame_data[i];
                b.keep = frame_keep[i];
                b.last = (i == len - 1);
                b.good = good;
                send_beat(b, gaps ? int'(seed[29:28]) : 0);
            end
        end
    endtask

    task automatic set_out_mode(input int mode);
        @(negedge clk);
        out_mode = mode;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int num, input string name);
        int n;
        n = 0;
        while ((check_i.pending() != 0 || out_valid) && n < 5000) begin
            @(posedge clk);
            #1;
            n++;
        end
        repeat (20) @(posedge clk);  // room for a stray beat to show up
        #1;
        check_i.report_leftover(num);
        if (error_total() == test_errors)
            $display("test %0d %s: passed", num, name);
        else
            $display("test %0d %s: failed", num, name);
        test_errors = error_total();
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        plan_frames(1, 0);
        plan_frames(7, 1);
        plan_frames(20, 0);
        plan_frames(12, 0);
        plan_frames(120, 2);
        watchdog_cycles = total_beats * 20 + 2000;
        test_errors = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        set_out_mode(OUT_HIGH);
        send_frames(1, 1'b0);
        finish_test(1, "single good frame");

        send_frames(7, 1'b0);
        finish_test(2, "bad frames dropped");

        set_out_mode(OUT_RAND);
        send_frames(20, 1'b0);
        finish_test(3, "random output ready");

        set_out_mode(OUT_LOW);
        stall_seen = 1'b0;
        fork
            send_frames(12, 1'b0);
            begin
                for (int n = 0; n < 4000 && !stall_seen; n++) begin
                    @(negedge clk);
                    stall_seen = in_valid && !in_ready;
                end
                repeat (50) @(negedge clk);
                out_mode = OUT_HIGH;  // let the backlog drain
            end
        join
        if (!stall_seen) begin
            $display("test 4: input ready never fell while the output was held off");
            tb_errors++;
        end
        finish_test(4, "output held off");

        set_out_mode(OUT_RAND);
        send_frames(120, 1'b1);
        finish_test(5, "long random mix");

        $display("%0d tests run, %0d beats checked, %0d failures",
                 5, check_i.checked, error_total());
        if (error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== testbench/frame_buffer_check.sv ====
`timescale 1ns/1ps

module frame_buffer_check (
    input logic                i_clk,
    input logic                i_rst,
    input fram_pkg::out_beat_t i_out,
    input logic                i_out_valid,
    input logic                i_out_ready
);

    fram_pkg::out_beat_t exp_q[$];  // filled by the reference function
    fram_pkg::out_beat_t held;
    logic                held_valid = 1'b0;
    int                  errors = 0;
    int                  checked = 0;

    function automatic void expect_beat(input fram_pkg::out_beat_t b);
        exp_q.push_back(b);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic void report_leftover(input int test_num);
        if (exp_q.size() != 0) begin
            $display("test %0d: %0d expected output beats never came out",
                     test_num, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endfunction

    // sampled mid-cycle where the handshake has settled
    always @(negedge i_clk) begin
        fram_pkg::out_beat_t want;
        if (!i_rst) begin
            if (held_valid && (!i_out_valid || i_out != held)) begin
                $display("Error at %0d ns: output beat changed while stalled", $time);
                errors++;
            end
            if (i_out_valid && i_out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0d ns: unexpected output beat %h", $time, i_out);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    checked++;
                    if (i_out !== want) begin
                        // fields are data keep last user
                        $display("Error at %0d ns: got %h/%h/%b/%0d want %h/%h/%b/%0d",
                                 $time, i_out.data, i_out.keep, i_out.last, i_out.user,
                                 want.data, want.keep, want.last, want.user);
                        errors++;
                    end
                end
            end
            held_valid = i_out_valid && !i_out_ready;
            held       = i_out;
        end
    end

endmodule

// ==== testbench/frame_buffer_props.sv ====
`timescale 1ns/1ps

module frame_buffer_props (
    input logic                i_clk,
    input logic                i_rst,
    input fram_pkg::out_beat_t i_out,
    input logic                i_out_valid,
    input logic                i_out_ready,
    input logic                i_in_ready,
    input logic                i_push,
    input logic                i_fifo_full
);

    // a stalled output beat stays put until it is taken
    out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out))
        else $error("output beat dropped or changed under back-pressure");

    quiet_in_reset: assert property (@(posedge i_clk)
        i_rst |-> !i_out_valid && !i_in_ready)
        else $error("stream handshake active during reset");

    no_push_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
        i_push |-> !i_fifo_full)
        else $error("descriptor pushed into a full FIFO");

endmodule

bind frame_buffer frame_buffer_props props_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_out       (o_out),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_in_ready  (o_in_ready),
    .i_push      (push),
    .i_fifo_full (fifo_full)
);

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer (
    input  logic                i_clk,
    input  logic                i_rst,
    // input stream
    input  fram_pkg::in_beat_t  i_in,
    input  logic                i_in_valid,
    output logic                o_in_ready,
    // output stream
    output fram_pkg::out_beat_t o_out,
    output logic                o_out_valid,
    input  logic                i_out_ready
);

    // writer to RAM
    logic            we;
    fram_pkg::addr_t waddr;
    fram_pkg::beat_t wdata;

    // writer and reader to FIFO
    logic            push;
    fram_pkg::desc_t desc;
    logic            fifo_full;
    logic            pop;
    fram_pkg::desc_t head;
    logic            fifo_empty;

    // reader to RAM
    logic            re;
    fram_pkg::addr_t raddr;
    fram_pkg::beat_t rdata;
    fram_pkg::addr_t rd_ptr;  // back to the writer for the space check

    frame_writer writer_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_in        (i_in),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_fifo_full (fifo_full),
        .i_rd_ptr    (rd_ptr),
        .o_we        (we),
        .o_waddr     (waddr),
        .o_wdata     (wdata),
        .o_push      (push),
        .o_desc      (desc)
    );

    frame_ram ram_i (
        .i_clk   (i_clk),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .i_re    (re),
        .i_raddr (raddr),
        .o_rdata (rdata)
    );

    desc_fifo fifo_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (push),
        .i_desc  (desc),
        .o_full  (fifo_full),
        .i_pop   (pop),
        .o_head  (head),
        .o_empty (fifo_empty)
    );

    frame_reader reader_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_empty     (fifo_empty),
        .i_head      (head),
        .o_pop       (pop),
        .o_re        (re),
        .o_raddr     (raddr),
        .o_rd_ptr    (rd_ptr),
        .i_rdata     (rdata),
        .o_out       (o_out),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready)
    );

endmodule

// ==== hdl/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader (
    input  logic                i_clk,
    input  logic                i_rst,
    // descriptor FIFO
    input  logic                i_empty,
    input  fram_pkg::desc_t     i_head,
    output logic                o_pop,
    // RAM read port
    output logic                o_re,
    output fram_pkg::addr_t     o_raddr,
    output fram_pkg::addr_t     o_rd_ptr,
    input  fram_pkg::beat_t     i_rdata,
    // output stream
    output fram_pkg::out_beat_t o_out,
    output logic                o_out_valid,
    input  logic                i_out_ready
);

    fram_pkg::rd_state_t state;
    fram_pkg::addr_t     rd_ptr;     // next beat not yet issued
    fram_pkg::len_t      remain;     // beats of this frame still to issue
    fram_pkg::len_t      frame_len;

    // tag of the beat sitting in the RAM output register
    logic                fl_valid;
    logic                fl_last;
    fram_pkg::len_t      fl_len;
    fram_pkg::out_beat_t fl_beat;

    // two-entry output buffer
    fram_pkg::out_beat_t ob_mem [2];
    logic                ob_wr;
    logic                ob_rd;
    logic [1:0]          ob_cnt;

    logic                out_xfer;
    logic [2:0]          occ;
    logic                room;
    logic                issue;

    assign o_pop    = (state == fram_pkg::IDLE) && !i_empty;
    assign out_xfer = o_out_valid && i_out_ready;

    // beats in flight plus buffered, minus the one leaving now
    assign occ   = 3'(fl_valid) + 3'(ob_cnt) - 3'(out_xfer);
    assign room  = (occ < 3'd2);
    assign issue = (state == fram_pkg::READ) && room;

    assign o_re        = issue;
    assign o_raddr     = rd_ptr;
    assign o_rd_ptr    = rd_ptr;
    assign o_out_valid = (ob_cnt != 2'd0);
    assign o_out       = ob_mem[ob_rd];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state  <= fram_pkg::IDLE;
            rd_ptr <= '0;
            remain <= '0;
        end else if (o_pop) begin
            state  <= fram_pkg::READ;
            rd_ptr <= i_head.start;
            remain <= i_head.len;
        end else if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
            remain <= remain - 1'b1;
            if (remain == fram_pkg::len_t'(1)) begin
                state <= fram_pkg::IDLE;  // last beat issued
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            frame_len <= i_head.len;
        end
        if (issue) begin
            fl_last <= (remain == fram_pkg::len_t'(1));
            fl_len  <= frame_len;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            fl_valid <= 1'b0;
        end else begin
            fl_valid <= issue;  // RAM data valid one cycle after issue
        end
    end

    always_comb begin
        fl_beat.data = i_rdata.data;
        fl_beat.keep = i_rdata.keep;
        fl_beat.last = fl_last;
        fl_beat.user = fl_len;
    end

    always_ff @(posedge i_clk) begin
        if (fl_valid) begin
            ob_mem[ob_wr] <= fl_beat;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ob_wr  <= 1'b0;
            ob_rd  <= 1'b0;
            ob_cnt <= 2'd0;
        end else begin
            if (fl_valid) begin
                ob_wr <= ~ob_wr;
            end
            if (out_xfer) begin
                ob_rd <= ~ob_rd;
            end
            ob_cnt <= ob_cnt + 2'(fl_valid) - 2'(out_xfer);
        end
    end

endmodule

// ==== hdl/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer (
    input  logic               i_clk,
    input  logic               i_rst,
    // input stream
    input  fram_pkg::in_beat_t i_in,
    input  logic               i_in_valid,
    output logic               o_in_ready,
    // space information
    input  logic               i_fifo_full,
    input  fram_pkg::addr_t    i_rd_ptr,
    // RAM write port
    output logic               o_we,
    output fram_pkg::addr_t    o_waddr,
    output fram_pkg::beat_t    o_wdata,
    // descriptor push
    output logic               o_push,
    output fram_pkg::desc_t    o_desc
);

    logic            ready_en;  // low in reset, high from the first edge after
    fram_pkg::addr_t wr_ptr;
    fram_pkg::addr_t wr_next;
    fram_pkg::addr_t start;     // first address of the frame being written
    fram_pkg::len_t  beat_cnt;  // beats accepted so far in this frame
    logic            accept;

    assign wr_next = wr_ptr + 1'b1;

    // one slot kept free so a full RAM never looks empty to the reader
    assign o_in_ready = ready_en && !i_fifo_full && (wr_next != i_rd_ptr);
    assign accept     = i_in_valid && o_in_ready;

    assign o_we    = accept;
    assign o_waddr = wr_ptr;
    assign o_push  = accept && i_in.last && i_in.good;

    always_comb begin
        o_wdata.data = i_in.data;
        o_wdata.keep = i_in.keep;
        o_desc.start = start;
        o_desc.len   = beat_cnt + 1'b1;  // count includes the last beat
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            start    <= '0;
            beat_cnt <= '0;
        end else if (accept) begin
            if (!i_in.last) begin
                wr_ptr   <= wr_next;
                beat_cnt <= beat_cnt + 1'b1;
            end else if (i_in.good) begin
                // frame kept, next one starts right behind it
                wr_ptr   <= wr_next;
                start    <= wr_next;
                beat_cnt <= '0;
            end else begin
                wr_ptr   <= start;  // bad frame, throw its beats away
                beat_cnt <= '0;
            end
        end
    end

endmodule

// ==== hdl/desc_fifo.sv ====
`timescale 1ns/1ps

module desc_fifo (
    input  logic            i_clk,
    input  logic            i_rst,
    // push side
    input  logic            i_push,
    input  fram_pkg::desc_t i_desc,
    output logic            o_full,
    // pop side, first word fall-through
    input  logic            i_pop,
    output fram_pkg::desc_t o_head,
    output logic            o_empty
);

    fram_pkg::desc_t     mem [fram_pkg::DESC_DEPTH];
    fram_pkg::desc_ptr_t wr_ptr;
    fram_pkg::desc_ptr_t rd_ptr;
    fram_pkg::desc_cnt_t count;
    logic                do_push;
    logic                do_pop;

    assign o_full  = (count == fram_pkg::desc_cnt_t'(fram_pkg::DESC_DEPTH));
    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];  // head straight from the read pointer

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_desc;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
    input  logic            i_clk,
    // write port
    input  logic            i_we,
    input  fram_pkg::addr_t i_waddr,
    input  fram_pkg::beat_t i_wdata,
    // read port
    input  logic            i_re,
    input  fram_pkg::addr_t i_raddr,
    output fram_pkg::beat_t o_rdata
);

    fram_pkg::beat_t mem [fram_pkg::RAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, output holds between reads
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== hdl/fram_pkg.sv ====
package fram_pkg;

    localparam int DATA_W     = 32;
    localparam int KEEP_W     = DATA_W / 8;
    localparam int RAM_DEPTH  = 256;
    localparam int ADDR_W     = 8;
    localparam int DESC_DEPTH = 8;
    localparam int DESC_AW    = 3;           // log2 of DESC_DEPTH
    localparam int LEN_W      = ADDR_W + 1;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [KEEP_W-1:0]  keep_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [DESC_AW-1:0] desc_ptr_t;
    typedef logic [DESC_AW:0]   desc_cnt_t;  // one extra bit to tell full from empty

    // one stored RAM word
    typedef struct packed {
        data_t data;
        keep_t keep;
    } beat_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  good;   // only looked at with last
    } in_beat_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        len_t  user;   // frame length in beats
    } out_beat_t;

    typedef struct packed {
        addr_t start;
        len_t  len;
    } desc_t;

    typedef enum logic {
        IDLE,
        READ
    } rd_state_t;

endpackage
